//--- Makefile
# Verilator build and run of the pingpong_stage testbench

TOOL     = verilator
FLAGS    = --binary --timing
TOP      = pp_tb
FILELIST = pingpong_stage.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "PASS: all tests" $(LOG); then \
		echo "Log check: passed"; \
	else \
		echo "Log check: failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- common/pp_pkg.sv
// ********************
// Element widths, operand word types
// and configuration register map
// ********************
package pp_pkg;

    // One matrix element
    localparam int DATA_W = 8;

    // A west word feeds two array rows
    localparam int W_LANES = 2;

    // Largest bank is 32 entries
    localparam int MAX_DEPTH_LOG = 5;

    // West operand word, lane 0 in the low bits
    typedef logic [W_LANES*DATA_W-1:0] w_word_t;

    // North operand, one element
    typedef logic [DATA_W-1:0] n_word_t;

    // Tile length, one bit wider than an address so that 32 fits
    typedef logic [MAX_DEPTH_LOG:0] dim_t;

    // Configuration port
    typedef logic       cfg_addr_t;
    typedef logic [7:0] cfg_data_t;

    // Register map
    localparam cfg_addr_t CFG_DIM_ADDR  = 1'b0;
    // Bit 0 is the enable
    localparam cfg_addr_t CFG_CTRL_ADDR = 1'b1;

endpackage

//--- pingpong_stage.f
common/pp_pkg.sv
pp_ctrl/pp_cfg_regs.sv
pp_ctrl/pp_ctrl.sv
pp_bank/pp_bank_pair.sv
rtl/pingpong_stage.sv
tests/pp_tb_clk.sv
tests/pp_tb.sv

//--- pp_bank/pp_bank_pair.sv
// ********************
// West and north operand banks,
// two of each, with role steering
// ********************
`timescale 1ns/1ns

module pp_bank_pair #(
    parameter int DEPTH = 16
) (
    input  logic                     clk_i,
    input  logic                     wr_en_i,
    input  logic [$clog2(DEPTH)-1:0] wr_addr_i,
    input  logic                     fill_sel_i,
    input  pp_pkg::w_word_t          w_din_i,
    input  pp_pkg::n_word_t          n_din_i,
    input  logic [$clog2(DEPTH)-1:0] rd_addr_i,
    output pp_pkg::w_word_t          w_dout_o,
    output pp_pkg::n_word_t          n_dout_o
);
    import pp_pkg::*;

    // Register arrays
    w_word_t w_bank0 [DEPTH];
    w_word_t w_bank1 [DEPTH];
    n_word_t n_bank0 [DEPTH];
    n_word_t n_bank1 [DEPTH];

    logic    bank0_we;
    logic    bank1_we;
    logic    drain_sel;

    w_word_t w_rd0;
    w_word_t w_rd1;
    n_word_t n_rd0;
    n_word_t n_rd1;

    // Only the fill bank takes writes
    assign bank0_we  = wr_en_i & ~fill_sel_i;
    assign bank1_we  = wr_en_i &  fill_sel_i;
    assign drain_sel = ~fill_sel_i;

    always_ff @(posedge clk_i) begin
        if (bank0_we) begin
            w_bank0[wr_addr_i] <= w_din_i;
            n_bank0[wr_addr_i] <= n_din_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (bank1_we) begin
            w_bank1[wr_addr_i] <= w_din_i;
            n_bank1[wr_addr_i] <= n_din_i;
        end
    end

    // Asynchronous read of both banks
    assign w_rd0 = w_bank0[rd_addr_i];
    assign w_rd1 = w_bank1[rd_addr_i];
    assign n_rd0 = n_bank0[rd_addr_i];
    assign n_rd1 = n_bank1[rd_addr_i];

    // Each west lane feeds its own array row
    for (genvar l = 0; l < W_LANES; l++) begin : g_w_lane
        assign w_dout_o[l*DATA_W +: DATA_W] = drain_sel
                                              ? w_rd1[l*DATA_W +: DATA_W]
                                              : w_rd0[l*DATA_W +: DATA_W];
    end

    assign n_dout_o = drain_sel ? n_rd1 : n_rd0;

endmodule

//--- pp_ctrl/pp_cfg_regs.sv
// ********************
// Tile length and enable registers
// ********************
`timescale 1ns/1ns

module pp_cfg_regs #(
    parameter int DEPTH = 16
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              cfg_we_i,
    input  pp_pkg::cfg_addr_t cfg_addr_i,
    input  pp_pkg::cfg_data_t cfg_wdata_i,
    output pp_pkg::cfg_data_t cfg_rdata_o,
    output pp_pkg::dim_t      tile_dim_o,
    output logic              enable_o
);
    import pp_pkg::*;

    dim_t dim_q;
    logic enable_q;
    dim_t dim_clamped;

    // Written length is forced into 1..DEPTH
    always_comb begin
        if (cfg_wdata_i == '0) begin
            dim_clamped = dim_t'(1);
        end else if (cfg_wdata_i > cfg_data_t'(DEPTH)) begin
            dim_clamped = dim_t'(DEPTH);
        end else begin
            dim_clamped = dim_t'(cfg_wdata_i);
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dim_q    <= dim_t'(1);
            enable_q <= 1'b0;
        end else if (cfg_we_i) begin
            if (cfg_addr_i == CFG_DIM_ADDR) begin
                dim_q <= dim_clamped;
            end else begin
                enable_q <= cfg_wdata_i[0];
            end
        end
    end

    // Zero-latency readback
    always_comb begin
        if (cfg_addr_i == CFG_CTRL_ADDR) begin
            cfg_rdata_o = {7'b0, enable_q};
        end else begin
            cfg_rdata_o = cfg_data_t'(dim_q);
        end
    end

    assign tile_dim_o = dim_q;
    assign enable_o   = enable_q;

endmodule

//--- pp_ctrl/pp_ctrl.sv
// ********************
// Fill and drain controller with
// bank role swap and handshakes
// ********************
`timescale 1ns/1ns

module pp_ctrl #(
    parameter int DEPTH = 16
) (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  pp_pkg::dim_t             tile_dim_i,
    input  logic                     enable_i,
    input  logic                     in_valid_i,
    output logic                     in_ready_o,
    input  logic                     out_ready_i,
    output logic                     out_valid_o,
    output logic                     out_last_o,
    output logic                     wr_en_o,
    output logic [$clog2(DEPTH)-1:0] wr_addr_o,
    output logic [$clog2(DEPTH)-1:0] rd_addr_o,
    output logic                     fill_sel_o
);
    import pp_pkg::*;

    localparam int AW = $clog2(DEPTH);

    // Bank role, fill side is fill_sel and drain side the other one
    logic          fill_sel;
    logic          drain_sel;
    logic [AW-1:0] fill_cnt;
    logic [AW-1:0] drain_cnt;
    logic          fill_full;
    logic          drain_busy;

    // Tile length captured per bank at its first beat
    dim_t          len_q [2];

    dim_t          fill_len;
    dim_t          drain_len;
    logic          fill_last;
    logic          in_fire;
    logic          out_fire;
    logic          drain_done;
    logic          swap;

    assign drain_sel = ~fill_sel;

    // First beat of a fill still sees the live config value
    assign fill_len  = (fill_cnt == '0) ? tile_dim_i : len_q[fill_sel];
    assign drain_len = len_q[drain_sel];
    assign fill_last = (dim_t'(fill_cnt) == fill_len - dim_t'(1));

    // Input side
    assign in_ready_o = enable_i & ~fill_full;
    assign in_fire    = in_valid_i & in_ready_o;

    // Output side
    assign out_valid_o = drain_busy;
    assign out_last_o  = drain_busy & (dim_t'(drain_cnt) == drain_len - dim_t'(1));
    assign out_fire    = out_valid_o & out_ready_i;
    assign drain_done  = out_fire & out_last_o;

    // Full bank moves to the drain side once the drain is free
    assign swap = fill_full & (~drain_busy | drain_done);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fill_sel  <= 1'b0;
            fill_cnt  <= '0;
            fill_full <= 1'b0;
            len_q[0]  <= dim_t'(1);
            len_q[1]  <= dim_t'(1);
        end else begin
            if (in_fire) begin
                if (fill_cnt == '0) begin
                    len_q[fill_sel] <= tile_dim_i;
                end
                if (fill_last) begin
                    fill_cnt  <= '0;
                    fill_full <= 1'b1;
                end else begin
                    fill_cnt <= fill_cnt + AW'(1);
                end
            end
            // No input beat can land here, in_ready_o is low while full
            if (swap) begin
                fill_full <= 1'b0;
                fill_sel  <= ~fill_sel;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            drain_busy <= 1'b0;
            drain_cnt  <= '0;
        end else begin
            if (swap) begin
                drain_busy <= 1'b1;
                drain_cnt  <= '0;
            end else if (drain_done) begin
                drain_busy <= 1'b0;
                drain_cnt  <= '0;
            end else if (out_fire) begin
                drain_cnt <= drain_cnt + AW'(1);
            end
        end
    end

    // Bank pair steering
    assign wr_en_o    = in_fire;
    assign wr_addr_o  = fill_cnt;
    assign rd_addr_o  = drain_cnt;
    assign fill_sel_o = fill_sel;

endmodule

//--- rtl/pingpong_stage.sv
// ********************
// Double-buffered operand staging top
// ********************
`timescale 1ns/1ns

module pingpong_stage #(
    parameter int DEPTH = 16
) (
    input  logic              clk_i,
    input  logic              rst_n_i,

    // Input stream
    input  logic              in_valid_i,
    output logic              in_ready_o,
    input  pp_pkg::w_word_t   w_din_i,
    input  pp_pkg::n_word_t   n_din_i,

    // Output stream to the array
    output logic              out_valid_o,
    input  logic              out_ready_i,
    output pp_pkg::w_word_t   w_dout_o,
    output pp_pkg::n_word_t   n_dout_o,
    output logic              out_last_o,

    // Configuration
    input  logic              cfg_we_i,
    input  pp_pkg::cfg_addr_t cfg_addr_i,
    input  pp_pkg::cfg_data_t cfg_wdata_i,
    output pp_pkg::cfg_data_t cfg_rdata_o
);
    import pp_pkg::*;

    localparam int AW = $clog2(DEPTH);

    dim_t          tile_dim;
    logic          enable;
    logic          wr_en;
    logic [AW-1:0] wr_addr;
    logic [AW-1:0] rd_addr;
    logic          fill_sel;

    pp_cfg_regs #(
        .DEPTH       (DEPTH)
    ) i_pp_cfg_regs (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_rdata_o (cfg_rdata_o),
        .tile_dim_o  (tile_dim),
        .enable_o    (enable)
    );

    pp_ctrl #(
        .DEPTH       (DEPTH)
    ) i_pp_ctrl (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .tile_dim_i  (tile_dim),
        .enable_i    (enable),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .out_ready_i (out_ready_i),
        .out_valid_o (out_valid_o),
        .out_last_o  (out_last_o),
        .wr_en_o     (wr_en),
        .wr_addr_o   (wr_addr),
        .rd_addr_o   (rd_addr),
        .fill_sel_o  (fill_sel)
    );

    pp_bank_pair #(
        .DEPTH       (DEPTH)
    ) i_pp_bank_pair (
        .clk_i       (clk_i),
        .wr_en_i     (wr_en),
        .wr_addr_i   (wr_addr),
        .fill_sel_i  (fill_sel),
        .w_din_i     (w_din_i),
        .n_din_i     (n_din_i),
        .rd_addr_i   (rd_addr),
        .w_dout_o    (w_dout_o),
        .n_dout_o    (n_dout_o)
    );

endmodule

//--- tests/pp_tb.sv
// ********************
// Testbench top with tile table,
// stimulus generator and checks
// ********************
`timescale 1ns/1ns

module pp_tb;
    import pp_pkg::*;

    localparam int DEPTH = 16;
    localparam int NT    = 9;
    localparam int TMO   = 200;

    // One tile of stimulus
    // Stall pattern bit 1 means out_ready_i high and rotates once per cycle
    typedef struct packed {
        logic [7:0]  dim;
        logic        en;
        logic [15:0] stall;
        logic        rnd;
        logic        chain;
        logic        ovl;
    } tile_t;

    logic      clk_i;
    logic      rst_n_i;
    logic      in_valid_i;
    logic      in_ready_o;
    w_word_t   w_din_i;
    n_word_t   n_din_i;
    logic      out_valid_o;
    logic      out_ready_i;
    w_word_t   w_dout_o;
    n_word_t   n_dout_o;
    logic      out_last_o;
    logic      cfg_we_i;
    cfg_addr_t cfg_addr_i;
    cfg_data_t cfg_wdata_i;
    cfg_data_t cfg_rdata_o;

    tile_t       tiles [NT];
    w_word_t     exp_w [$];
    n_word_t     exp_n [$];
    logic        exp_last [$];
    int unsigned rng = 84931;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_bad;
    // Tiles fully written and fully read as counted at the clock edge
    int          filled;
    int          drained;
    int          ovl_cnt;
    logic        in_take;
    logic        out_take;

    pp_tb_clk i_pp_tb_clk (
        .clk_o   (clk_i),
        .rst_n_o (rst_n_i)
    );

    pingpong_stage #(
        .DEPTH       (DEPTH)
    ) i_pingpong_stage (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .w_din_i     (w_din_i),
        .n_din_i     (n_din_i),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .w_dout_o    (w_dout_o),
        .n_dout_o    (n_dout_o),
        .out_last_o  (out_last_o),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_rdata_o (cfg_rdata_o)
    );

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Length the DUT should use after clamping into 1..DEPTH
    function automatic int expected_len(input logic [7:0] dim);
        if (dim == 8'd0) begin
            return 1;
        end
        if (int'(dim) > DEPTH) begin
            return DEPTH;
        end
        return int'(dim);
    endfunction

    task automatic check_w_word(input string name, input w_word_t exp, input w_word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected 0x%h, got 0x%h", name, exp, act);
        end
    endtask

    task automatic check_n_word(input string name, input n_word_t exp, input n_word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected 0x%h, got 0x%h", name, exp, act);
        end
    endtask

    task automatic check_cfg(input string name, input cfg_data_t exp, input cfg_data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected 0x%h, got 0x%h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected 0x%h, got 0x%h", name, exp, act);
        end
    endtask

    task automatic report_test(input string label, input int err0);
        tests_run++;
        if (errors > err0) begin
            tests_bad++;
            $display("test %s: %0d errors", label, errors - err0);
        end else begin
            $display("test %s: ok", label);
        end
    endtask

    // Called on a falling edge and returns on the next one
    task automatic cfg_write(input cfg_addr_t addr, input cfg_data_t data);
        in_valid_i  = 1'b0;
        cfg_we_i    = 1'b1;
        cfg_addr_i  = addr;
        cfg_wdata_i = data;
        @(negedge clk_i);
        cfg_we_i = 1'b0;
    endtask

    // Readback sampled half a cycle after the address settles
    task automatic cfg_expect(input cfg_addr_t addr, input cfg_data_t exp);
        cfg_addr_i = addr;
        @(posedge clk_i);
        check_cfg("cfg_rdata_o", exp, cfg_rdata_o);
        @(negedge clk_i);
    endtask

    task automatic send_beat(input w_word_t w, input n_word_t n, input logic last);
        int wait_cyc;
        wait_cyc   = 0;
        in_valid_i = 1'b1;
        w_din_i    = w;
        n_din_i    = n;
        while (!in_ready_o && wait_cyc < TMO) begin
            @(negedge clk_i);
            wait_cyc++;
        end
        if (!in_ready_o) begin
            errors++;
            $display("Input beat was not accepted within %0d cycles", TMO);
        end else begin
            in_take = 1'b1;
            exp_w.push_back(w);
            exp_n.push_back(n);
            exp_last.push_back(last);
            @(posedge clk_i);
            if (last) begin
                filled++;
            end
            @(negedge clk_i);
            in_take = 1'b0;
        end
        in_valid_i = 1'b0;
    endtask

    // Next tile length is written during the current fill
    task automatic produce(input int first, input int last_idx);
        int len;
        for (int k = first; k <= last_idx; k++) begin
            len = expected_len(tiles[k].dim);
            for (int i = 0; i < len; i++) begin
                rng = lcg_next(rng);
                send_beat(rng[23:8], rng[31:24], i == len - 1);
                if (i == 0 && k < last_idx) begin
                    cfg_write(CFG_DIM_ADDR, tiles[k+1].dim);
                end
            end
        end
    endtask

    task automatic consume(input int total, input logic [15:0] mask);
        int          got;
        int          idle;
        logic [15:0] rot;
        logic        held;
        logic        exp_l;
        w_word_t     w_hold;
        n_word_t     n_hold;
        logic        l_hold;
        got  = 0;
        idle = 0;
        rot  = mask;
        held = 1'b0;
        while (got < total && idle < TMO) begin
            @(negedge clk_i);
            // A stalled beat must not move
            if (held) begin
                check_bit("out_valid_o", 1'b1, out_valid_o);
                check_w_word("w_dout_o", w_hold, w_dout_o);
                check_n_word("n_dout_o", n_hold, n_dout_o);
                check_bit("out_last_o", l_hold, out_last_o);
            end
            // Both banks occupied
            if (filled - drained >= 2) begin
                check_bit("in_ready_o", 1'b0, in_ready_o);
            end
            out_ready_i = rot[0];
            rot         = {rot[0], rot[15:1]};
            held        = out_valid_o & ~out_ready_i;
            w_hold      = w_dout_o;
            n_hold      = n_dout_o;
            l_hold      = out_last_o;
            out_take    = out_valid_o & out_ready_i;
            exp_l       = 1'b0;
            if (out_take) begin
                idle = 0;
                if (exp_w.size() == 0) begin
                    errors++;
                    $display("Output beat arrived with no input beat left to match");
                end else begin
                    exp_l = exp_last.pop_front();
                    check_w_word("w_dout_o", exp_w.pop_front(), w_dout_o);
                    check_n_word("n_dout_o", exp_n.pop_front(), n_dout_o);
                    check_bit("out_last_o", exp_l, out_last_o);
                end
                got++;
            end else begin
                idle++;
            end
            @(posedge clk_i);
            if (out_take && in_take) begin
                ovl_cnt++;
            end
            if (out_take && exp_l) begin
                drained++;
            end
        end
        @(negedge clk_i);
        out_take    = 1'b0;
        out_ready_i = 1'b0;
        if (got < total) begin
            errors++;
            $display("Only %0d of %0d output beats arrived before the timeout", got, total);
        end
        // Nothing more may follow the last beat
        check_bit("out_valid_o", 1'b0, out_valid_o);
    endtask

    task automatic run_group(input int first, input int last_idx);
        int          total;
        int          err0;
        logic [15:0] mask;
        total = 0;
        err0  = errors;
        for (int k = first; k <= last_idx; k++) begin
            total += expected_len(tiles[k].dim);
        end
        mask = tiles[first].stall;
        if (tiles[first].rnd) begin
            rng  = lcg_next(rng);
            mask = (rng[15:0] & rng[31:16]) | 16'h0101;
        end
        ovl_cnt = 0;
        cfg_write(CFG_CTRL_ADDR, {7'b0, tiles[first].en});
        cfg_write(CFG_DIM_ADDR, tiles[first].dim);
        if (!tiles[first].en) begin
            in_valid_i = 1'b1;
            for (int c = 0; c < 20; c++) begin
                @(negedge clk_i);
                check_bit("in_ready_o", 1'b0, in_ready_o);
            end
            in_valid_i = 1'b0;
        end else begin
            fork
                produce(first, last_idx);
                consume(total, mask);
            join
            if (tiles[first].ovl && ovl_cnt == 0) begin
                errors++;
                $display("No cycle moved an input beat and an output beat together");
            end
            if (exp_w.size() != 0) begin
                errors++;
                $display("%0d input beats never came out", exp_w.size());
                exp_w.delete();
                exp_n.delete();
                exp_last.delete();
            end
        end
        report_test($sformatf("rows %0d-%0d", first, last_idx), err0);
    endtask

    initial begin
        int first;
        int err0;
        int wait_cyc;
        in_valid_i  = 1'b0;
        w_din_i     = '0;
        n_din_i     = '0;
        out_ready_i = 1'b0;
        cfg_we_i    = 1'b0;
        cfg_addr_i  = CFG_DIM_ADDR;
        cfg_wdata_i = '0;
        in_take     = 1'b0;
        out_take    = 1'b0;
        errors      = 0;
        checks      = 0;
        tests_run   = 0;
        tests_bad   = 0;
        filled      = 0;
        drained     = 0;
        ovl_cnt     = 0;

        // dim, enable, stall pattern, random stalls, chained, overlap expected
        tiles[0] = '{8'd5, 1'b0, 16'hffff, 1'b0, 1'b0, 1'b0};
        tiles[1] = '{8'd7, 1'b1, 16'hffff, 1'b0, 1'b0, 1'b0};
        tiles[2] = '{8'd4, 1'b1, 16'hffff, 1'b0, 1'b1, 1'b1};
        tiles[3] = '{8'd4, 1'b1, 16'hffff, 1'b0, 1'b1, 1'b1};
        tiles[4] = '{8'd4, 1'b1, 16'hffff, 1'b0, 1'b0, 1'b1};
        tiles[5] = '{8'd6, 1'b1, 16'h0000, 1'b1, 1'b1, 1'b0};
        tiles[6] = '{8'd6, 1'b1, 16'h0000, 1'b1, 1'b0, 1'b0};
        tiles[7] = '{8'd3, 1'b1, 16'hffff, 1'b0, 1'b1, 1'b0};
        tiles[8] = '{8'd9, 1'b1, 16'hffff, 1'b0, 1'b0, 1'b0};

        wait_cyc = 0;
        while (rst_n_i !== 1'b1 && wait_cyc < 10) begin
            @(posedge clk_i);
            wait_cyc++;
        end
        if (rst_n_i !== 1'b1) begin
            errors++;
            $display("Reset was never released");
        end
        @(negedge clk_i);

        // Reset values and then clamping of the tile length
        err0 = errors;
        cfg_expect(CFG_DIM_ADDR, 8'd1);
        cfg_expect(CFG_CTRL_ADDR, 8'd0);
        cfg_write(CFG_DIM_ADDR, 8'd5);
        cfg_expect(CFG_DIM_ADDR, 8'd5);
        cfg_write(CFG_DIM_ADDR, 8'd0);
        cfg_expect(CFG_DIM_ADDR, 8'd1);
        cfg_write(CFG_DIM_ADDR, 8'd40);
        cfg_expect(CFG_DIM_ADDR, 8'd16);
        report_test("config readback", err0);

        first = 0;
        for (int k = 0; k < NT; k++) begin
            if (!tiles[k].chain) begin
                run_group(first, k);
                first = k + 1;
            end
        end

        $display("tests %0d, failing tests %0d, checks %0d, errors %0d",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- tests/pp_tb_clk.sv
// ********************
// Testbench clock and reset
// ********************
`timescale 1ns/1ns

module pp_tb_clk (
    output logic clk_o,
    output logic rst_n_o
);
    // 20 ns period
    initial begin
        clk_o = 1'b0;
        forever begin
            #10 clk_o = ~clk_o;
        end
    end

    // Reset held for three cycles, released on a falling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (3) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule
